/* source/osd_stm_pkg.sv */
`default_nettype none

package osd_stm_pkg;

   // Debug interconnect geometry
   localparam int flit_width      = 16;
   localparam int timestamp_width = 32;

   // Packet classes, top two bits of the type word
   localparam logic [1:0] pkt_type_reg   = 2'd0;
   localparam logic [1:0] pkt_type_event = 2'd2;

   // Register request and response subtypes
   localparam logic [3:0] sub_req_read   = 4'd0;
   localparam logic [3:0] sub_req_write  = 4'd1;
   localparam logic [3:0] sub_resp_read  = 4'd8;
   localparam logic [3:0] sub_resp_write = 4'd9;
   localparam logic [3:0] sub_resp_error = 4'd10;

   // Event subtypes
   localparam logic [3:0] sub_event_trace    = 4'd0;
   localparam logic [3:0] sub_event_overflow = 4'd1;

   // Third header word, seen either as a plain flit or split into its fields
   typedef union packed {
      logic [15:0] raw;
      struct packed {
         logic [1:0] pkt_type;
         logic [3:0] subtype;
         logic [9:0] reserved;
      } fields;
   } pkt_type_word_t;

   // Register map
   localparam logic [15:0] reg_addr_vendor      = 16'h0000;
   localparam logic [15:0] reg_addr_type        = 16'h0001;
   localparam logic [15:0] reg_addr_version     = 16'h0002;
   localparam logic [15:0] reg_addr_control     = 16'h0003;
   localparam logic [15:0] reg_addr_event_dest  = 16'h0004;
   localparam logic [15:0] reg_addr_value_width = 16'h0200;

   // Module identity
   localparam logic [15:0] mod_vendor  = 16'h0001;
   localparam logic [15:0] mod_type    = 16'h0004;
   localparam logic [15:0] mod_version = 16'h0000;

endpackage

`default_nettype wire

/* source/stm_trace_sample.sv */
`default_nettype none

module stm_trace_sample #(
   parameter int value_width = 64
) (
   input  wire                                     clk,
   input  wire                                     rst_n,
   input  wire                                     stall,
   input  wire                                     trace_valid,
   input  wire  [osd_stm_pkg::flit_width-1:0]      trace_id,
   input  wire  [value_width-1:0]                  trace_value,
   output logic [osd_stm_pkg::timestamp_width-1:0] out_timestamp,
   output logic [osd_stm_pkg::flit_width-1:0]      out_trace_id,
   output logic [value_width-1:0]                  out_value,
   output logic                                    out_overflow,
   output logic                                    out_valid,
   input  wire                                     out_ready
);
   import osd_stm_pkg::*;

   logic [timestamp_width-1:0] timestamp;
   logic [flit_width-1:0]      lost_count;
   logic                       accept;
   logic                       slot_free;
   logic                       send_overflow;

   assign accept        = trace_valid && !stall;
   assign slot_free     = !out_valid || out_ready;
   assign send_overflow = lost_count != '0;

   // Free-running timestamp
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         timestamp <= '0;
      end else begin
         timestamp <= timestamp + 1'b1;
      end
   end

   // A pending loss report takes the slot before any new event
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         lost_count <= '0;
      end else if (slot_free) begin
         if (send_overflow) begin
            out_valid  <= 1'b1;
            // An event arriving now is already counted in the next report
            lost_count <= flit_width'(accept);
         end else begin
            out_valid <= accept;
         end
      end else if (accept && lost_count != '1) begin
         lost_count <= lost_count + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (slot_free && (send_overflow || accept)) begin
         out_timestamp <= timestamp;
         out_overflow  <= send_overflow;
         out_trace_id  <= send_overflow ? lost_count : trace_id;
         out_value     <= send_overflow ? '0 : trace_value;
      end
   end

endmodule

`default_nettype wire

/* source/stm_event_fifo.sv */
`default_nettype none

module stm_event_fifo #(
   parameter int width = 113,
   parameter int depth = 8
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire  [width-1:0] in_data,
   input  wire              in_valid,
   output logic             in_ready,
   output logic [width-1:0] out_data,
   output logic             out_valid,
   input  wire              out_ready
);

   localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_width = $clog2(depth + 1);

   logic [width-1:0]     mem [depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic [cnt_width-1:0] fill;
   logic                 push;
   logic                 pop;

   // Pointers wrap at depth, which need not be a power of two
   function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
      return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign in_ready  = fill != cnt_width'(depth);
   assign out_valid = fill != '0;
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push && !pop) begin
            fill <= fill + 1'b1;
         end else if (pop && !push) begin
            fill <= fill - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

endmodule

`default_nettype wire

/* source/stm_trace_packetizer.sv */
`default_nettype none

module stm_trace_packetizer #(
   parameter int value_width = 64
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [osd_stm_pkg::flit_width-1:0] id,
   input  wire  [osd_stm_pkg::flit_width-1:0] event_dest,
   input  wire  [value_width + osd_stm_pkg::timestamp_width + osd_stm_pkg::flit_width:0]
                                              entry_data,
   input  wire                                entry_valid,
   output logic                               entry_ready,
   output logic [osd_stm_pkg::flit_width-1:0] out_data,
   output logic                               out_last,
   output logic                               out_valid,
   input  wire                                out_ready
);
   import osd_stm_pkg::*;

   localparam int entry_width = value_width + timestamp_width + flit_width + 1;
   localparam int value_words = value_width / flit_width;
   // Three header words, two timestamp words and the id or count word
   localparam int value_first = 6;
   localparam int cnt_width   = $clog2(value_first + value_words);

   logic [entry_width-1:0]     entry;
   logic                       busy;
   logic [cnt_width-1:0]       word_cnt;
   logic [cnt_width-1:0]       last_word;
   logic [cnt_width-1:0]       value_idx;
   logic [timestamp_width-1:0] ent_timestamp;
   logic [flit_width-1:0]      ent_trace_id;
   logic [value_width-1:0]     ent_value;
   logic                       ent_overflow;
   pkt_type_word_t             type_word;

   assign {ent_overflow, ent_value, ent_trace_id, ent_timestamp} = entry;

   assign entry_ready = !busy;
   assign out_valid   = busy;
   assign value_idx   = word_cnt - cnt_width'(value_first);
   assign last_word   = ent_overflow ? cnt_width'(value_first - 1)
                                     : cnt_width'(value_first + value_words - 1);
   assign out_last    = word_cnt == last_word;

   always_comb begin
      type_word.fields.pkt_type = pkt_type_event;
      type_word.fields.subtype  = ent_overflow ? sub_event_overflow : sub_event_trace;
      type_word.fields.reserved = '0;
   end

   always_comb begin
      case (int'(word_cnt))
         0:       out_data = event_dest;
         1:       out_data = id;
         2:       out_data = type_word.raw;
         3:       out_data = ent_timestamp[flit_width-1:0];
         4:       out_data = ent_timestamp[timestamp_width-1:flit_width];
         5:       out_data = ent_trace_id;
         // Value words, lowest first
         default: out_data = flit_width'(ent_value >> (flit_width * int'(value_idx)));
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         word_cnt <= '0;
      end else if (!busy) begin
         if (entry_valid) begin
            busy     <= 1'b1;
            word_cnt <= '0;
         end
      end else if (out_ready) begin
         if (out_last) begin
            busy <= 1'b0;
         end
         word_cnt <= word_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (entry_valid && entry_ready) begin
         entry <= entry_data;
      end
   end

endmodule

`default_nettype wire

/* source/stm_reg_access.sv */
`default_nettype none

module stm_reg_access #(
   parameter int value_width = 64
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [osd_stm_pkg::flit_width-1:0] id,
   input  wire  [osd_stm_pkg::flit_width-1:0] in_data,
   input  wire                                in_last,
   input  wire                                in_valid,
   output logic                               in_ready,
   output logic [osd_stm_pkg::flit_width-1:0] out_data,
   output logic                               out_last,
   output logic                               out_valid,
   input  wire                                out_ready,
   output logic                               stall,
   output logic [osd_stm_pkg::flit_width-1:0] event_dest
);
   import osd_stm_pkg::*;

   // Words seen in the current request, saturating
   logic [2:0]            in_cnt;
   logic [flit_width-1:0] req_src;
   logic [flit_width-1:0] req_addr;
   logic [flit_width-1:0] req_wdata;
   pkt_type_word_t        req_type;
   logic                  resp_pending;
   logic [1:0]            resp_cnt;
   logic                  is_read;
   logic                  is_write;
   logic                  addr_readable;
   logic                  addr_writable;
   logic                  read_ok;
   logic                  write_ok;
   logic [flit_width-1:0] rdata;
   pkt_type_word_t        resp_type;

   assign in_ready  = !resp_pending;
   assign out_valid = resp_pending;

   // A request is well formed only with exactly the words its subtype needs
   assign is_read  = req_type.fields.pkt_type == pkt_type_reg &&
                     req_type.fields.subtype == sub_req_read && in_cnt == 3'd4;
   assign is_write = req_type.fields.pkt_type == pkt_type_reg &&
                     req_type.fields.subtype == sub_req_write && in_cnt == 3'd5;

   always_comb begin
      addr_readable = 1'b1;
      addr_writable = 1'b0;
      rdata         = '0;
      case (req_addr)
         reg_addr_vendor:      rdata = mod_vendor;
         reg_addr_type:        rdata = mod_type;
         reg_addr_version:     rdata = mod_version;
         reg_addr_control: begin
            rdata         = {{(flit_width - 1){1'b0}}, stall};
            addr_writable = 1'b1;
         end
         reg_addr_event_dest: begin
            rdata         = event_dest;
            addr_writable = 1'b1;
         end
         reg_addr_value_width: rdata = flit_width'(value_width);
         default:              addr_readable = 1'b0;
      endcase
   end

   assign read_ok  = is_read && addr_readable;
   assign write_ok = is_write && addr_writable;

   always_comb begin
      resp_type.fields.pkt_type = pkt_type_reg;
      resp_type.fields.reserved = '0;
      if (read_ok) begin
         resp_type.fields.subtype = sub_resp_read;
      end else if (write_ok) begin
         resp_type.fields.subtype = sub_resp_write;
      end else begin
         resp_type.fields.subtype = sub_resp_error;
      end
   end

   // Only a successful read carries a data word
   assign out_last = read_ok ? (resp_cnt == 2'd3) : (resp_cnt == 2'd2);

   always_comb begin
      case (resp_cnt)
         2'd0:    out_data = req_src;
         2'd1:    out_data = id;
         2'd2:    out_data = resp_type.raw;
         default: out_data = rdata;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_cnt       <= '0;
         resp_pending <= 1'b0;
         resp_cnt     <= '0;
         stall        <= 1'b1;
         event_dest   <= '0;
      end else if (!resp_pending) begin
         if (in_valid) begin
            if (in_cnt != 3'd7) begin
               in_cnt <= in_cnt + 1'b1;
            end
            if (in_last) begin
               resp_pending <= 1'b1;
               resp_cnt     <= '0;
            end
         end
      end else if (out_ready) begin
         resp_cnt <= resp_cnt + 1'b1;
         if (out_last) begin
            resp_pending <= 1'b0;
            in_cnt       <= '0;
            // Writes take effect as the response completes
            if (write_ok && req_addr == reg_addr_control) begin
               stall <= req_wdata[0];
            end
            if (write_ok && req_addr == reg_addr_event_dest) begin
               event_dest <= req_wdata;
            end
         end
      end
   end

   // Word 0 is our own address and is not kept
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         case (in_cnt)
            3'd1:    req_src <= in_data;
            3'd2:    req_type.raw <= in_data;
            3'd3:    req_addr <= in_data;
            3'd4:    req_wdata <= in_data;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/stm_out_arbiter.sv */
`default_nettype none

module stm_out_arbiter (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [osd_stm_pkg::flit_width-1:0] req0_data,
   input  wire                                req0_last,
   input  wire                                req0_valid,
   output logic                               req0_ready,
   input  wire  [osd_stm_pkg::flit_width-1:0] req1_data,
   input  wire                                req1_last,
   input  wire                                req1_valid,
   output logic                               req1_ready,
   output logic [osd_stm_pkg::flit_width-1:0] out_data,
   output logic                               out_last,
   output logic                               out_valid,
   input  wire                                out_ready
);

   // One-hot owner of the open packet, zero between packets
   logic [1:0] grant;
   logic       last_winner;
   logic       pick;
   logic       sel;

   // Round-robin choice for the next packet
   always_comb begin
      if (req0_valid && req1_valid) begin
         pick = !last_winner;
      end else begin
         pick = req1_valid;
      end
   end

   assign sel        = (grant == 2'b00) ? pick : grant[1];
   assign out_data   = sel ? req1_data : req0_data;
   assign out_last   = sel ? req1_last : req0_last;
   assign out_valid  = sel ? req1_valid : req0_valid;
   assign req0_ready = out_ready && !sel;
   assign req1_ready = out_ready && sel;

   // Lock as soon as a flit is offered so a stalled first flit keeps its owner
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         grant       <= 2'b00;
         last_winner <= 1'b1;
      end else if (out_valid) begin
         if (out_ready && out_last) begin
            grant       <= 2'b00;
            last_winner <= sel;
         end else begin
            grant <= sel ? 2'b10 : 2'b01;
         end
      end
   end

endmodule

`default_nettype wire

/* source/osd_stm.sv */
`default_nettype none

module osd_stm #(
   parameter int value_width = 64,
   parameter int fifo_depth  = 8
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [osd_stm_pkg::flit_width-1:0] id,
   input  wire  [osd_stm_pkg::flit_width-1:0] debug_in_data,
   input  wire                                debug_in_last,
   input  wire                                debug_in_valid,
   output wire                                debug_in_ready,
   output wire  [osd_stm_pkg::flit_width-1:0] debug_out_data,
   output wire                                debug_out_last,
   output wire                                debug_out_valid,
   input  wire                                debug_out_ready,
   input  wire                                trace_valid,
   input  wire  [osd_stm_pkg::flit_width-1:0] trace_id,
   input  wire  [value_width-1:0]             trace_value
);
   import osd_stm_pkg::*;

   // Overflow flag, value, trace id and timestamp
   localparam int entry_width = 1 + value_width + flit_width + timestamp_width;

   logic                       stall;
   logic [flit_width-1:0]      event_dest;

   logic [flit_width-1:0]      resp_data;
   logic                       resp_last;
   logic                       resp_valid;
   logic                       resp_ready;

   logic [timestamp_width-1:0] sample_timestamp;
   logic [flit_width-1:0]      sample_trace_id;
   logic [value_width-1:0]     sample_value;
   logic                       sample_overflow;
   logic                       sample_valid;
   logic                       sample_ready;

   logic [entry_width-1:0]     entry_data;
   logic                       entry_valid;
   logic                       entry_ready;

   logic [flit_width-1:0]      event_data;
   logic                       event_last;
   logic                       event_valid;
   logic                       event_ready;

   stm_reg_access #(
      .value_width (value_width)
   ) u_reg_access (
      .clk        (clk),
      .rst_n      (rst_n),
      .id         (id),
      .in_data    (debug_in_data),
      .in_last    (debug_in_last),
      .in_valid   (debug_in_valid),
      .in_ready   (debug_in_ready),
      .out_data   (resp_data),
      .out_last   (resp_last),
      .out_valid  (resp_valid),
      .out_ready  (resp_ready),
      .stall      (stall),
      .event_dest (event_dest)
   );

   stm_trace_sample #(
      .value_width (value_width)
   ) u_sample (
      .clk           (clk),
      .rst_n         (rst_n),
      .stall         (stall),
      .trace_valid   (trace_valid),
      .trace_id      (trace_id),
      .trace_value   (trace_value),
      .out_timestamp (sample_timestamp),
      .out_trace_id  (sample_trace_id),
      .out_value     (sample_value),
      .out_overflow  (sample_overflow),
      .out_valid     (sample_valid),
      .out_ready     (sample_ready)
   );

   stm_event_fifo #(
      .width (entry_width),
      .depth (fifo_depth)
   ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_data   ({sample_overflow, sample_value, sample_trace_id, sample_timestamp}),
      .in_valid  (sample_valid),
      .in_ready  (sample_ready),
      .out_data  (entry_data),
      .out_valid (entry_valid),
      .out_ready (entry_ready)
   );

   stm_trace_packetizer #(
      .value_width (value_width)
   ) u_packetizer (
      .clk         (clk),
      .rst_n       (rst_n),
      .id          (id),
      .event_dest  (event_dest),
      .entry_data  (entry_data),
      .entry_valid (entry_valid),
      .entry_ready (entry_ready),
      .out_data    (event_data),
      .out_last    (event_last),
      .out_valid   (event_valid),
      .out_ready   (event_ready)
   );

   // Register responses on port 0, trace events on port 1
   stm_out_arbiter u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .req0_data  (resp_data),
      .req0_last  (resp_last),
      .req0_valid (resp_valid),
      .req0_ready (resp_ready),
      .req1_data  (event_data),
      .req1_last  (event_last),
      .req1_valid (event_valid),
      .req1_ready (event_ready),
      .out_data   (debug_out_data),
      .out_last   (debug_out_last),
      .out_valid  (debug_out_valid),
      .out_ready  (debug_out_ready)
   );

endmodule

`default_nettype wire

/* sim/tb_osd_stm.sv */
`default_nettype none

module tb_osd_stm;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int value_width = 64;
   localparam int fifo_depth  = 8;
   localparam logic [15:0] dut_id  = 16'h0010;
   localparam logic [15:0] host_id = 16'h0001;

   // Type word: class in bits 15:14, subtype in bits 13:10
   localparam logic [3:0]  req_read      = 4'd0;
   localparam logic [3:0]  req_write     = 4'd1;
   localparam logic [3:0]  resp_read     = 4'd8;
   localparam logic [3:0]  resp_write    = 4'd9;
   localparam logic [3:0]  resp_error    = 4'd10;
   localparam logic [15:0] trace_word    = {2'd2, 4'd0, 10'd0};
   localparam logic [15:0] overflow_word = {2'd2, 4'd1, 10'd0};

   // Table operations
   localparam logic [2:0] op_read    = 3'd0;
   localparam logic [2:0] op_write   = 3'd1;
   localparam logic [2:0] op_quiet   = 3'd2;
   localparam logic [2:0] op_burst   = 3'd3;
   localparam logic [2:0] op_blocked = 3'd4;
   localparam logic [2:0] op_mixed   = 3'd5;
   localparam logic [2:0] op_hold    = 3'd6;

   localparam int num_rows    = 16;
   localparam int cycle_limit = 10 + num_rows * 500;

   typedef struct packed {
      logic [2:0]  op;
      logic [15:0] arg;
      logic [15:0] data;
      logic [3:0]  exp_sub;
      logic [15:0] exp_data;
   } row_t;

   typedef struct packed {
      logic [4:0]        len;
      logic [15:0][15:0] w;
   } packet_t;

   typedef struct packed {
      logic [3:0]  sub;
      logic [15:0] data;
   } resp_t;

   logic                   clk;
   logic                   rst_n;
   logic [15:0]            debug_in_data;
   logic                   debug_in_last;
   logic                   debug_in_valid;
   wire                    debug_in_ready;
   wire  [15:0]            debug_out_data;
   wire                    debug_out_last;
   wire                    debug_out_valid;
   logic                   debug_out_ready;
   logic                   trace_valid;
   logic [15:0]            trace_id;
   logic [value_width-1:0] trace_value;

   row_t        rows [num_rows];
   packet_t     rx [$];
   resp_t       exp_resp [$];
   logic [15:0] exp_ids [$];
   logic [15:0] model_dest;
   logic [31:0] last_ts;
   logic [15:0] next_seq;
   logic [1:0]  ready_mode;
   integer      seed;
   int          error_count;
   int          cycle_count;

   osd_stm #(
      .value_width (value_width),
      .fifo_depth  (fifo_depth)
   ) i_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .id              (dut_id),
      .debug_in_data   (debug_in_data),
      .debug_in_last   (debug_in_last),
      .debug_in_valid  (debug_in_valid),
      .debug_in_ready  (debug_in_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready),
      .trace_valid     (trace_valid),
      .trace_id        (trace_id),
      .trace_value     (trace_value)
   );

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0.1f ns: %s, got %h expected %h", $realtime, what, got, exp);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // Stimulus value words, lowest first: seq, ~seq, seq + 0x1111, seq ^ 0x5a5a
   function automatic logic [63:0] make_value(input logic [15:0] seq);
      return {seq ^ 16'h5a5a, seq + 16'h1111, ~seq, seq};
   endfunction

   task automatic hold_cycles(input logic [15:0] n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Called and returns 1 ns after a rising edge
   task automatic send_word(input logic [15:0] data, input logic last);
      debug_in_data  = data;
      debug_in_last  = last;
      debug_in_valid = 1'b1;
      do begin
         @(negedge clk);
      end while (!debug_in_ready);
      @(posedge clk);
      #1;
      debug_in_valid = 1'b0;
   endtask

   task automatic send_request(input logic [3:0] sub, input logic [15:0] addr,
                               input logic [15:0] data);
      send_word(dut_id, 1'b0);
      send_word(host_id, 1'b0);
      send_word({2'd0, sub, 10'd0}, 1'b0);
      if (sub == req_write) begin
         send_word(addr, 1'b0);
         send_word(data, 1'b1);
      end else begin
         send_word(addr, 1'b1);
      end
   endtask

   task automatic issue_events(input logic [15:0] count, input logic track);
      repeat (count) begin
         trace_valid = 1'b1;
         trace_id    = next_seq;
         trace_value = make_value(next_seq);
         if (track) begin
            exp_ids.push_back(next_seq);
         end
         next_seq = next_seq + 16'd1;
         @(posedge clk);
         #1;
      end
      trace_valid = 1'b0;
   endtask

   // Monitor side, sampled mid-cycle where the link is stable
   task automatic collect_packet(output packet_t pkt);
      logic done;
      pkt  = '0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (rst_n && debug_out_valid && debug_out_ready) begin
            check_value("packet longer than 16 words", 16'(pkt.len < 5'd16), 16'd1);
            pkt.w[pkt.len[3:0]] = debug_out_data;
            pkt.len = pkt.len + 5'd1;
            done = debug_out_last;
         end
      end
   endtask

   task automatic wait_packet(output packet_t pkt);
      while (rx.size() == 0) begin
         @(posedge clk);
         #1;
      end
      pkt = rx.pop_front();
   endtask

   task automatic check_timestamp(input packet_t pkt);
      logic [31:0] ts;
      ts = {pkt.w[4], pkt.w[3]};
      check_value("timestamp increase", 16'(ts > last_ts), 16'd1);
      last_ts = ts;
   endtask

   task automatic check_packet(input packet_t pkt);
      resp_t       exp_r;
      logic [15:0] seq;
      logic [63:0] value;
      check_value("packet source", pkt.w[1], dut_id);
      if (pkt.w[2][15:14] == 2'd0) begin
         check_value("response expected", 16'(exp_resp.size() != 0), 16'd1);
         exp_r = exp_resp.pop_front();
         check_value("response destination", pkt.w[0], host_id);
         check_value("response type word", pkt.w[2], {2'd0, exp_r.sub, 10'd0});
         if (exp_r.sub == resp_read) begin
            check_value("read response length", 16'(pkt.len), 16'd4);
            check_value("read data", pkt.w[3], exp_r.data);
         end else begin
            check_value("response length", 16'(pkt.len), 16'd3);
         end
      end else begin
         check_value("event type word", pkt.w[2], trace_word);
         check_value("event expected", 16'(exp_ids.size() != 0), 16'd1);
         seq   = exp_ids.pop_front();
         value = make_value(seq);
         check_value("event destination", pkt.w[0], model_dest);
         check_value("event length", 16'(pkt.len), 16'd10);
         check_timestamp(pkt);
         check_value("trace id", pkt.w[5], seq);
         for (int k = 0; k < 4; k++) begin
            check_value("value word", pkt.w[6 + k], value[16 * k +: 16]);
         end
      end
   endtask

   task automatic drain_expected();
      packet_t pkt;
      while (exp_resp.size() != 0 || exp_ids.size() != 0) begin
         wait_packet(pkt);
         check_packet(pkt);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Mode 0 ready, 1 held low, 2 random; mode is taken at the edge
   initial begin
      logic [1:0]  mode;
      logic [31:0] rnd;
      debug_out_ready = 1'b0;
      forever begin
         @(posedge clk);
         mode = ready_mode;
         #1;
         rnd = $random(seed);
         debug_out_ready = (mode == 2'd0) || (mode == 2'd2 && rnd[0]);
      end
   end

   initial begin
      packet_t pkt;
      forever begin
         collect_packet(pkt);
         rx.push_back(pkt);
      end
   end

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk);
         cycle_count++;
         if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1);
         end
      end
   end

   initial begin
      row_t    row;
      packet_t pkt;
      logic    overflow_seen;
      rows = '{
         '{op_read,    16'h0000, 16'h0000, resp_read,  16'h0001},
         '{op_read,    16'h0001, 16'h0000, resp_read,  16'h0004},
         '{op_read,    16'h0002, 16'h0000, resp_read,  16'h0000},
         '{op_read,    16'h0200, 16'h0000, resp_read,  16'd64},
         '{op_read,    16'h0055, 16'h0000, resp_error, 16'h0000},
         '{op_write,   16'h0000, 16'h0005, resp_error, 16'h0000},
         '{op_write,   16'h0004, 16'h0123, resp_write, 16'h0000},
         '{op_read,    16'h0004, 16'h0000, resp_read,  16'h0123},
         '{op_read,    16'h0003, 16'h0000, resp_read,  16'h0001},
         '{op_quiet,   16'd3,    16'h0000, 4'd0,       16'h0000},
         '{op_write,   16'h0003, 16'h0000, resp_write, 16'h0000},
         '{op_read,    16'h0003, 16'h0000, resp_read,  16'h0000},
         '{op_burst,   16'd4,    16'h0000, 4'd0,       16'h0000},
         '{op_blocked, 16'd14,   16'h0000, 4'd0,       16'h0000},
         '{op_mixed,   16'd6,    16'h0200, resp_read,  16'd64},
         '{op_hold,    16'd40,   16'h0000, 4'd0,       16'h0000}
      };
      seed           = 32'hb1b5;
      error_count    = 0;
      ready_mode     = 2'd0;
      model_dest     = 16'h0000;
      last_ts        = 32'h0;
      next_seq       = 16'h0100;
      rst_n          = 1'b0;
      debug_in_data  = 16'h0000;
      debug_in_last  = 1'b0;
      debug_in_valid = 1'b0;
      trace_valid    = 1'b0;
      trace_id       = 16'h0000;
      trace_value    = '0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < num_rows; i++) begin
         row = rows[i];
         case (row.op)
            op_read: begin
               exp_resp.push_back(resp_t'{row.exp_sub, row.exp_data});
               send_request(req_read, row.arg, 16'h0000);
               drain_expected();
            end
            op_write: begin
               exp_resp.push_back(resp_t'{row.exp_sub, 16'h0000});
               if (row.exp_sub == resp_write && row.arg == 16'h0004) begin
                  model_dest = row.data;
               end
               send_request(req_write, row.arg, row.data);
               drain_expected();
            end
            op_quiet: begin
               // Tracing is stalled, so nothing may come out
               issue_events(row.arg, 1'b0);
               hold_cycles(16'd30);
               check_value("packets while stalled", 16'(rx.size()), 16'd0);
            end
            op_burst: begin
               issue_events(row.arg, 1'b1);
               drain_expected();
            end
            op_blocked: begin
               ready_mode = 2'd1;
               issue_events(row.arg, 1'b1);
               hold_cycles(16'd5);
               ready_mode    = 2'd0;
               overflow_seen = 1'b0;
               while (!overflow_seen) begin
                  wait_packet(pkt);
                  if (pkt.w[2] == overflow_word) begin
                     check_value("overflow source", pkt.w[1], dut_id);
                     check_value("overflow destination", pkt.w[0], model_dest);
                     check_value("overflow length", 16'(pkt.len), 16'd6);
                     check_timestamp(pkt);
                     // Events never delivered are still queued here
                     check_value("lost event count", pkt.w[5], 16'(exp_ids.size()));
                     exp_ids.delete();
                     overflow_seen = 1'b1;
                  end else begin
                     check_packet(pkt);
                  end
               end
            end
            op_mixed: begin
               ready_mode = 2'd2;
               fork
                  issue_events(row.arg, 1'b1);
                  begin
                     repeat (2) begin
                        exp_resp.push_back(resp_t'{row.exp_sub, row.exp_data});
                        send_request(req_read, row.data, 16'h0000);
                     end
                  end
               join
               drain_expected();
               ready_mode = 2'd0;
            end
            default: begin
               hold_cycles(row.arg);
               check_value("unexpected packets", 16'(rx.size()), 16'd0);
            end
         endcase
      end

      check_value("leftover packets", 16'(rx.size()), 16'd0);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
source/osd_stm_pkg.sv
source/stm_trace_sample.sv
source/stm_event_fifo.sv
source/stm_trace_packetizer.sv
source/stm_reg_access.sv
source/stm_out_arbiter.sv
source/osd_stm.sv
sim/tb_osd_stm.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass message in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_osd_stm \
   --Mdir obj_dir -o tb_osd_stm \
   && ./obj_dir/tb_osd_stm 2>&1 | tee /dev/stderr | grep "NO ERRORS" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
